//--- rv_core.f
+incdir+design
design/rv_core_pkg.sv
design/bus_arbiter.sv
design/fetch_stage.sv
design/decode_stage.sv
design/regfile.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/rv_core.sv
test/tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# compile the testbench with Verilator, run it and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1

log=sim.log

rm -rf obj_dir

verilator --binary --timing -j 0 --top-module tb_rv_core -f rv_core.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

./obj_dir/Vtb_rv_core > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASSED" "$log"; then
  exit 0
fi

echo "pass message not found in $log"
exit 1

//--- test/tb_rv_core.sv
// testbench for rv_core with bus memory model, program builder and directed tests
`timescale 1ns/1ps

module tb_rv_core;

  localparam int          MEM_WORDS = 128;
  localparam int          TIMEOUT   = 5000;
  localparam logic [63:0] DONE_ADDR = 64'h3f8;
  localparam logic [9:0]  FN_ADD    = 10'b0000000_000;
  localparam logic [9:0]  FN_SUB    = 10'b0100000_000;
  localparam logic [9:0]  FN_AND    = 10'b0000000_111;
  localparam logic [9:0]  FN_OR     = 10'b0000000_110;
  localparam logic [9:0]  FN_XOR    = 10'b0000000_100;
  localparam logic [2:0]  BR_EQ     = 3'b000;
  localparam logic [2:0]  BR_NE     = 3'b001;

  logic                  clk         = 1'b0;
  logic                  i_rst_n     = 1'b0;
  logic                  i_mem_ready = 1'b0;
  logic [63:0]           i_mem_rdata = 64'h0;
  rv_core_pkg::bus_req_t o_mem_req;

  logic [63:0]           image [MEM_WORDS];
  logic [63:0]           mem [MEM_WORDS];
  logic [31:0]           prog [$];
  logic [63:0]           wr_log [$];
  rv_core_pkg::bus_req_t held;
  bit                    pending;
  bit                    done_seen;
  bit                    wait_mode;
  int                    wait_left;
  int                    bus_err;
  int                    seed = 90325;
  int                    errors;
  int                    tests_run;
  int                    tests_failed;

  rv_core dut0 (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .o_mem_req   (o_mem_req),
    .i_mem_ready (i_mem_ready),
    .i_mem_rdata (i_mem_rdata)
  );

  always #5 clk = ~clk;

  // memory model, reloads its image while the core is in reset
  always @(posedge clk) begin
    #1;
    if (!i_rst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] = image[i];
      end
      i_mem_ready = 1'b0;
      pending     = 1'b0;
      done_seen   = 1'b0;
      wr_log.delete();
    end else if (i_mem_ready) begin
      i_mem_ready = 1'b0;
      pending     = 1'b0;
    end else if (o_mem_req.valid) begin
      if (!pending) begin
        pending   = 1'b1;
        held      = o_mem_req;
        wait_left = wait_mode ? ($random(seed) & 3) : 0;
      end else if (o_mem_req != held) begin
        bus_err++;
      end
      if (wait_left == 0) begin
        if (held.op) begin
          mem[held.addr[9:3]] = held.wdata;
          wr_log.push_back(held.addr);
          if (held.addr == DONE_ADDR) done_seen = 1'b1;
        end else begin
          i_mem_rdata = mem[held.addr[9:3]];
        end
        i_mem_ready = 1'b1;
      end else begin
        wait_left--;
      end
    end else if (pending) begin
      // valid dropped before ready
      bus_err++;
    end
  end

  function automatic logic [31:0] alu_rr(input logic [9:0] fn, input int rd, input int rs1,
                                         input int rs2);
    alu_rr = {fn[9:3], rs2[4:0], rs1[4:0], fn[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    addi = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] ld(input int rd, input int rs1, input int imm);
    ld = {imm[11:0], rs1[4:0], 3'b011, rd[4:0], 7'b0000011};
  endfunction

  function automatic logic [31:0] sd(input int rs2, input int rs1, input int imm);
    sd = {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] lui(input int rd, input int upper);
    lui = {upper[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int imm);
    branch = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal(input int rd, input int imm);
    jal = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [63:0] fill_word(input int idx);
    logic [63:0] a;
    a = 64'(idx) << 3;
    fill_word = (a << 32) ^ a ^ 64'hc3c3_5a5a_0f0f_9696;
  endfunction

  // mark done, then spin on a jump to self
  task automatic push_done();
    prog.push_back(addi(31, 0, 'h3f8));
    prog.push_back(sd(31, 31, 0));
    prog.push_back(jal(0, 0));
  endtask

  task automatic run_program(input bit waits);
    int cycles;
    @(posedge clk);
    #1;
    i_rst_n   = 1'b0;
    wait_mode = waits;
    for (int i = 0; i < MEM_WORDS; i++) begin
      image[i] = fill_word(i);
    end
    for (int k = 0; k < prog.size(); k++) begin
      if (k % 2 == 1) image[k / 2][63:32] = prog[k];
      else image[k / 2][31:0] = prog[k];
    end
    repeat (16) @(posedge clk);
    #1;
    i_rst_n = 1'b1;
    cycles  = 0;
    while (!done_seen && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (!done_seen) begin
      $display("timeout: no store to the done address within %0d cycles", TIMEOUT);
      errors++;
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [63:0] addr, input logic [63:0] exp);
    check_value(name, exp, mem[addr[9:3]]);
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors) begin
      $display("%-12s ok", name);
    end else begin
      $display("%-12s failed with %0d errors", name, errors - start_errors);
      tests_failed++;
    end
  endtask

  task automatic arithmetic_test();
    int          start;
    logic [19:0] u;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    logic [63:0] exp [8];
    start = errors;
    u = 20'hfedcb;
    a = 64'd123;
    b = -64'd45;
    c = {{32{u[19]}}, u, 12'h000} + 64'd1656;
    exp = '{a, b, c, a + b, a - b, c & a, c | b, a ^ c};
    prog.delete();
    prog.push_back(addi(30, 0, 'h200));
    prog.push_back(addi(1, 0, 123));
    prog.push_back(addi(2, 0, -45));
    prog.push_back(lui(3, 'hfedcb));
    prog.push_back(addi(3, 3, 1656));
    prog.push_back(alu_rr(FN_ADD, 4, 1, 2));
    prog.push_back(alu_rr(FN_SUB, 5, 1, 2));
    prog.push_back(alu_rr(FN_AND, 6, 3, 1));
    prog.push_back(alu_rr(FN_OR, 7, 3, 2));
    prog.push_back(alu_rr(FN_XOR, 8, 1, 3));
    for (int r = 1; r <= 8; r++) begin
      prog.push_back(sd(r, 30, (r - 1) * 8));
    end
    push_done();
    run_program(1'b0);
    for (int r = 1; r <= 8; r++) begin
      check_word($sformatf("arithmetic x%0d", r), 64'h200 + 64'(r - 1) * 8, exp[r - 1]);
    end
    report_test("arithmetic", start);
  endtask

  task automatic zero_reg_test();
    int start;
    start = errors;
    prog.delete();
    prog.push_back(addi(30, 0, 'h200));
    prog.push_back(addi(0, 0, 55));
    prog.push_back(sd(0, 30, 0));
    prog.push_back(addi(9, 0, 7));
    prog.push_back(alu_rr(FN_ADD, 0, 9, 9));
    prog.push_back(alu_rr(FN_ADD, 10, 0, 9));
    prog.push_back(sd(10, 30, 8));
    prog.push_back(lui(0, 'h12345));
    prog.push_back(sd(0, 30, 16));
    push_done();
    run_program(1'b0);
    check_word("x0 after addi", 64'h200, 64'h0);
    check_word("x0 after add", 64'h208, 64'd7);
    check_word("x0 after lui", 64'h210, 64'h0);
    report_test("zero reg", start);
  endtask

  task automatic load_store_test();
    int          start;
    logic [63:0] v;
    start = errors;
    v = 64'd1445 + {32'h0, 20'h12345, 12'h000};
    prog.delete();
    prog.push_back(addi(30, 0, 'h200));
    prog.push_back(addi(1, 0, 'h5a5));
    prog.push_back(lui(2, 'h12345));
    prog.push_back(alu_rr(FN_ADD, 1, 1, 2));
    prog.push_back(sd(1, 30, 16));
    prog.push_back(ld(3, 30, 16));
    prog.push_back(addi(4, 0, 100));
    prog.push_back(alu_rr(FN_ADD, 5, 3, 4));
    prog.push_back(sd(5, 30, 24));
    prog.push_back(addi(29, 30, 64));
    prog.push_back(sd(5, 29, -8));
    push_done();
    run_program(1'b0);
    check_word("first store", 64'h210, v);
    check_word("load plus addend", 64'h218, v + 64'd100);
    check_word("negative offset", 64'h238, v + 64'd100);
    if (wr_log.size() < 3) begin
      $display("load store: only %0d bus writes were seen", wr_log.size());
      errors++;
    end else begin
      check_value("write address 0", 64'h210, wr_log[0]);
      check_value("write address 1", 64'h218, wr_log[1]);
      check_value("write address 2", 64'h238, wr_log[2]);
    end
    report_test("load store", start);
  endtask

  task automatic push_control();
    prog.push_back(addi(30, 0, 'h200));
    prog.push_back(addi(1, 0, 0));
    prog.push_back(addi(2, 0, 5));
    prog.push_back(addi(1, 1, 1));
    prog.push_back(branch(BR_NE, 1, 2, -4));
    prog.push_back(sd(1, 30, 0));
    prog.push_back(addi(3, 0, 7));
    prog.push_back(branch(BR_EQ, 3, 3, 8));
    // sits in the prefetched slot and must not execute
    prog.push_back(addi(3, 0, 99));
    prog.push_back(sd(3, 30, 8));
    prog.push_back(addi(4, 0, 1));
    prog.push_back(branch(BR_EQ, 4, 0, 8));
    prog.push_back(addi(4, 4, 2));
    prog.push_back(sd(4, 30, 16));
    prog.push_back(jal(5, 8));
    prog.push_back(addi(5, 0, 0));
    prog.push_back(sd(5, 30, 24));
  endtask

  task automatic check_control(input string tag);
    check_word({tag, " bne loop"}, 64'h200, 64'd5);
    check_word({tag, " beq taken"}, 64'h208, 64'd7);
    check_word({tag, " beq not taken"}, 64'h210, 64'd3);
    // jal sits at pc 56
    check_word({tag, " jal link"}, 64'h218, 64'd56 + 64'd4);
  endtask

  task automatic control_flow_test();
    int start;
    start = errors;
    prog.delete();
    push_control();
    push_done();
    run_program(1'b0);
    check_control("control");
    report_test("control", start);
  endtask

  // each pass stores, reloads and doubles the value
  task automatic push_store_loop();
    prog.push_back(addi(6, 0, 0));
    prog.push_back(addi(7, 0, 8));
    prog.push_back(addi(8, 30, 32));
    prog.push_back(addi(9, 0, 'h11));
    prog.push_back(sd(9, 8, 0));
    prog.push_back(ld(10, 8, 0));
    prog.push_back(alu_rr(FN_ADD, 9, 10, 9));
    prog.push_back(addi(8, 8, 8));
    prog.push_back(addi(6, 6, 1));
    prog.push_back(branch(BR_NE, 6, 7, -20));
  endtask

  task automatic check_store_loop(input string tag);
    for (int k = 0; k < 8; k++) begin
      check_word($sformatf("%s loop word %0d", tag, k), 64'h220 + 64'(k) * 8, 64'h11 << k);
    end
  endtask

  task automatic arbitration_test();
    int start;
    start = errors;
    prog.delete();
    push_control();
    push_store_loop();
    push_done();
    run_program(1'b0);
    check_control("no wait");
    check_store_loop("no wait");
    run_program(1'b1);
    check_control("wait states");
    check_store_loop("wait states");
    if (bus_err != 0) begin
      $display("bus request changed while valid was held without ready, %0d times", bus_err);
      errors++;
    end
    report_test("arbitration", start);
  endtask

  initial begin
    arithmetic_test();
    zero_reg_test();
    load_store_test();
    control_flow_test();
    arbitration_test();
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- design/rv_core.sv
// rv64 core top joining the stages, register file and bus arbiter
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_core (
  input  logic                  clk,
  input  logic                  i_rst_n,
  output rv_core_pkg::bus_req_t o_mem_req,
  input  logic                  i_mem_ready,
  input  logic [`RV_XLEN-1:0]   i_mem_rdata
);

  // stage pulses
  logic                   fetched;
  logic                   decoded;
  logic                   executed;
  logic                   retired;
  logic                   redirect;
  logic [`RV_XLEN-1:0]    redirect_pc;

  logic [`RV_XLEN-1:0]    fetch_pc;
  logic [`RV_ILEN-1:0]    fetch_inst;
  logic [`RV_RIDX_W-1:0]  rs1;
  logic [`RV_RIDX_W-1:0]  rs2;
  logic [`RV_XLEN-1:0]    rs1_data;
  logic [`RV_XLEN-1:0]    rs2_data;
  logic [`RV_RIDX_W-1:0]  rd;
  logic                   rd_wen;
  logic [`RV_XLEN-1:0]    rd_wdata;
  rv_core_pkg::decoded_t  dec;
  rv_core_pkg::executed_t ex;

  // bus ports
  rv_core_pkg::bus_req_t  if_req;
  rv_core_pkg::bus_req_t  dm_req;
  logic                   if_ready;
  logic                   dm_ready;

  fetch_stage fetch0 (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .o_bus_req     (if_req),
    .i_bus_ready   (if_ready),
    .i_bus_rdata   (i_mem_rdata),
    .i_retired     (retired),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .o_fetched     (fetched),
    .o_pc          (fetch_pc),
    .o_inst        (fetch_inst)
  );

  decode_stage decode0 (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_fetched  (fetched),
    .i_pc       (fetch_pc),
    .i_inst     (fetch_inst),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_decoded  (decoded),
    .o_dec      (dec)
  );

  regfile regfile0 (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_rd       (rd),
    .i_rd_wen   (rd_wen),
    .i_rd_wdata (rd_wdata)
  );

  execute_stage execute0 (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_decoded     (decoded),
    .i_dec         (dec),
    .o_executed    (executed),
    .o_ex          (ex),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc)
  );

  mem_wb_stage mem_wb0 (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_executed  (executed),
    .i_ex        (ex),
    .o_bus_req   (dm_req),
    .i_bus_ready (dm_ready),
    .i_bus_rdata (i_mem_rdata),
    .o_rd        (rd),
    .o_rd_wen    (rd_wen),
    .o_rd_wdata  (rd_wdata),
    .o_retired   (retired)
  );

  bus_arbiter arbiter0 (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_if_req    (if_req),
    .o_if_ready  (if_ready),
    .i_dm_req    (dm_req),
    .o_dm_ready  (dm_ready),
    .o_mem_req   (o_mem_req),
    .i_mem_ready (i_mem_ready)
  );

endmodule

//--- design/mem_wb_stage.sv
// memory access over the data port, register writeback and retire pulse
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module mem_wb_stage (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic                   i_executed,
  input  rv_core_pkg::executed_t i_ex,
  output rv_core_pkg::bus_req_t  o_bus_req,
  input  logic                   i_bus_ready,
  input  logic [`RV_XLEN-1:0]    i_bus_rdata,
  output logic [`RV_RIDX_W-1:0]  o_rd,
  output logic                   o_rd_wen,
  output logic [`RV_XLEN-1:0]    o_rd_wdata,
  output logic                   o_retired
);

  rv_core_pkg::mw_state_e state_q;
  rv_core_pkg::executed_t ex_q;
  logic [`RV_XLEN-1:0]    load_q;
  logic                   is_mem;

  assign is_mem = (i_ex.kind == rv_core_pkg::op_load) || (i_ex.kind == rv_core_pkg::op_store);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= rv_core_pkg::mw_idle;
    end else begin
      case (state_q)
        rv_core_pkg::mw_idle: begin
          if (i_executed) begin
            state_q <= is_mem ? rv_core_pkg::mw_access : rv_core_pkg::mw_write;
          end
        end
        rv_core_pkg::mw_access: begin
          if (i_bus_ready) state_q <= rv_core_pkg::mw_write;
        end
        default: state_q <= rv_core_pkg::mw_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_executed) begin
      ex_q <= i_ex;
    end
    if ((state_q == rv_core_pkg::mw_access) && i_bus_ready) begin
      load_q <= i_bus_rdata;
    end
  end

  // request held steady for the whole access state
  assign o_bus_req.valid = (state_q == rv_core_pkg::mw_access);
  assign o_bus_req.op    = (ex_q.kind == rv_core_pkg::op_store);
  assign o_bus_req.addr  = {ex_q.result[`RV_XLEN-1:3], 3'b000};
  assign o_bus_req.wdata = ex_q.store_data;

  assign o_rd       = ex_q.rd;
  assign o_rd_wen   = (state_q == rv_core_pkg::mw_write) && ex_q.rd_wen;
  assign o_rd_wdata = (ex_q.kind == rv_core_pkg::op_load) ? load_q : ex_q.result;
  assign o_retired  = (state_q == rv_core_pkg::mw_write);

endmodule

//--- design/execute_stage.sv
// execute stage with alu, branch compare, jump target and link value
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module execute_stage (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic                   i_decoded,
  input  rv_core_pkg::decoded_t  i_dec,
  output logic                   o_executed,
  output rv_core_pkg::executed_t o_ex,
  output logic                   o_redirect,
  output logic [`RV_XLEN-1:0]    o_redirect_pc
);

  logic [`RV_XLEN-1:0] alu_res;
  logic [`RV_XLEN-1:0] result;
  logic [`RV_XLEN-1:0] target;
  logic                taken;

  always_comb begin
    case (i_dec.alu_op)
      rv_core_pkg::alu_sub: alu_res = i_dec.op_a - i_dec.op_b;
      rv_core_pkg::alu_and: alu_res = i_dec.op_a & i_dec.op_b;
      rv_core_pkg::alu_or:  alu_res = i_dec.op_a | i_dec.op_b;
      rv_core_pkg::alu_xor: alu_res = i_dec.op_a ^ i_dec.op_b;
      default:              alu_res = i_dec.op_a + i_dec.op_b;
    endcase
  end

  // loads and stores get rs1 + imm from the adder
  always_comb begin
    case (i_dec.kind)
      rv_core_pkg::op_lui: result = i_dec.imm;
      rv_core_pkg::op_jal: result = i_dec.pc + 64'd4;
      default:             result = alu_res;
    endcase
  end

  assign target = i_dec.pc + i_dec.imm;
  assign taken  = (i_dec.kind == rv_core_pkg::op_jal) ||
                  ((i_dec.kind == rv_core_pkg::op_beq) && (i_dec.op_a == i_dec.op_b)) ||
                  ((i_dec.kind == rv_core_pkg::op_bne) && (i_dec.op_a != i_dec.op_b));

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_executed <= 1'b0;
      o_redirect <= 1'b0;
    end else begin
      o_executed <= i_decoded;
      o_redirect <= i_decoded && taken;
    end
  end

  always_ff @(posedge clk) begin
    if (i_decoded) begin
      o_ex.kind       <= i_dec.kind;
      o_ex.rd         <= i_dec.rd;
      o_ex.rd_wen     <= i_dec.rd_wen;
      o_ex.result     <= result;
      o_ex.store_data <= i_dec.store_data;
      o_redirect_pc   <= target;
    end
  end

endmodule

//--- design/regfile.sv
// integer register file, 32 x 64 bits with x0 held at zero
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module regfile (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic [`RV_RIDX_W-1:0] i_rs1,
  input  logic [`RV_RIDX_W-1:0] i_rs2,
  output logic [`RV_XLEN-1:0]   o_rs1_data,
  output logic [`RV_XLEN-1:0]   o_rs2_data,
  input  logic [`RV_RIDX_W-1:0] i_rd,
  input  logic                  i_rd_wen,
  input  logic [`RV_XLEN-1:0]   i_rd_wdata
);

  logic [`RV_XLEN-1:0] regs_q [`RV_NREGS];

  assign o_rs1_data = regs_q[i_rs1];
  assign o_rs2_data = regs_q[i_rs2];

  // x0 is cleared by reset and never written
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (i_rd_wen && (i_rd != '0)) begin
      regs_q[i_rd] <= i_rd_wdata;
    end
  end

endmodule

//--- design/decode_stage.sv
// decode stage with instruction register, field decode, immediates and operand read
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module decode_stage (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  logic                    i_fetched,
  input  logic [`RV_XLEN-1:0]     i_pc,
  input  logic [`RV_ILEN-1:0]     i_inst,
  output logic [`RV_RIDX_W-1:0]   o_rs1,
  output logic [`RV_RIDX_W-1:0]   o_rs2,
  input  logic [`RV_XLEN-1:0]     i_rs1_data,
  input  logic [`RV_XLEN-1:0]     i_rs2_data,
  output logic                    o_decoded,
  output rv_core_pkg::decoded_t   o_dec
);

  logic [`RV_XLEN-1:0]   pc_q;
  logic [`RV_ILEN-1:0]   inst_q;
  logic [`RV_XLEN-1:0]   rs1_q;
  logic [`RV_XLEN-1:0]   rs2_q;
  logic [`RV_XLEN-1:0]   imm_i;
  logic [`RV_XLEN-1:0]   imm_s;
  logic [`RV_XLEN-1:0]   imm_b;
  logic [`RV_XLEN-1:0]   imm_u;
  logic [`RV_XLEN-1:0]   imm_j;
  logic [`RV_XLEN-1:0]   imm;
  rv_core_pkg::op_kind_e kind;
  rv_core_pkg::alu_op_e  alu_op;

  // operands read while the fetched pulse is up
  assign o_rs1 = i_inst[`RV_RS1];
  assign o_rs2 = i_inst[`RV_RS2];

  always_ff @(posedge clk) begin
    if (i_fetched) begin
      pc_q   <= i_pc;
      inst_q <= i_inst;
      rs1_q  <= i_rs1_data;
      rs2_q  <= i_rs2_data;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_decoded <= 1'b0;
    end else begin
      o_decoded <= i_fetched;
    end
  end

  assign imm_i = {{52{inst_q[31]}}, inst_q[31:20]};
  assign imm_s = {{52{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
  assign imm_b = {{51{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_u = {{32{inst_q[31]}}, inst_q[31:12], 12'h000};
  assign imm_j = {{43{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

  // unsupported encodings fall out as op_nop
  always_comb begin
    kind   = rv_core_pkg::op_nop;
    alu_op = rv_core_pkg::alu_add;
    imm    = imm_i;
    case (inst_q[`RV_OPC])
      `RV_OPC_OP: begin
        case ({inst_q[`RV_F7], inst_q[`RV_F3]})
          10'b0000000_000: kind = rv_core_pkg::op_alu;
          10'b0100000_000: begin
            kind   = rv_core_pkg::op_alu;
            alu_op = rv_core_pkg::alu_sub;
          end
          10'b0000000_111: begin
            kind   = rv_core_pkg::op_alu;
            alu_op = rv_core_pkg::alu_and;
          end
          10'b0000000_110: begin
            kind   = rv_core_pkg::op_alu;
            alu_op = rv_core_pkg::alu_or;
          end
          10'b0000000_100: begin
            kind   = rv_core_pkg::op_alu;
            alu_op = rv_core_pkg::alu_xor;
          end
          default: kind = rv_core_pkg::op_nop;
        endcase
      end
      `RV_OPC_IMM: begin
        if (inst_q[`RV_F3] == 3'b000) kind = rv_core_pkg::op_alui;
      end
      `RV_OPC_LUI: begin
        kind = rv_core_pkg::op_lui;
        imm  = imm_u;
      end
      `RV_OPC_LOAD: begin
        if (inst_q[`RV_F3] == 3'b011) kind = rv_core_pkg::op_load;
      end
      `RV_OPC_STORE: begin
        imm = imm_s;
        if (inst_q[`RV_F3] == 3'b011) kind = rv_core_pkg::op_store;
      end
      `RV_OPC_BRANCH: begin
        imm = imm_b;
        if (inst_q[`RV_F3] == 3'b000) begin
          kind = rv_core_pkg::op_beq;
        end else if (inst_q[`RV_F3] == 3'b001) begin
          kind = rv_core_pkg::op_bne;
        end
      end
      `RV_OPC_JAL: begin
        kind = rv_core_pkg::op_jal;
        imm  = imm_j;
      end
      default: kind = rv_core_pkg::op_nop;
    endcase
  end

  always_comb begin
    o_dec.pc         = pc_q;
    o_dec.kind       = kind;
    o_dec.alu_op     = alu_op;
    o_dec.rd         = inst_q[`RV_RD];
    o_dec.rd_wen     = kind inside {rv_core_pkg::op_alu, rv_core_pkg::op_alui,
                                    rv_core_pkg::op_lui, rv_core_pkg::op_load,
                                    rv_core_pkg::op_jal};
    o_dec.op_a       = rs1_q;
    // register-register ops and branches compare or combine rs2
    o_dec.op_b       = (kind inside {rv_core_pkg::op_alu, rv_core_pkg::op_beq,
                                     rv_core_pkg::op_bne}) ? rs2_q : imm;
    o_dec.store_data = rs2_q;
    o_dec.imm        = imm;
  end

endmodule

//--- design/fetch_stage.sv
// fetch stage with program counter, one-instruction prefetch and redirect handling
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module fetch_stage (
  input  logic                  clk,
  input  logic                  i_rst_n,
  output rv_core_pkg::bus_req_t o_bus_req,
  input  logic                  i_bus_ready,
  input  logic [`RV_XLEN-1:0]   i_bus_rdata,
  input  logic                  i_retired,
  input  logic                  i_redirect,
  input  logic [`RV_XLEN-1:0]   i_redirect_pc,
  output logic                  o_fetched,
  output logic [`RV_XLEN-1:0]   o_pc,
  output logic [`RV_ILEN-1:0]   o_inst
);

  rv_core_pkg::bus_req_t req_q;
  logic [`RV_XLEN-1:0]   pc_q;
  logic [`RV_XLEN-1:0]   pc_next;
  logic [`RV_ILEN-1:0]   bus_inst;
  logic [`RV_ILEN-1:0]   hold_inst_q;
  logic [`RV_ILEN-1:0]   give_inst;
  logic                  hold_valid_q;
  logic                  busy_q;
  logic                  discard_q;
  logic                  free;
  logic                  bus_take;
  logic                  give;

  function automatic rv_core_pkg::bus_req_t fetch_req(input logic [`RV_XLEN-1:0] addr);
    fetch_req       = '0;
    fetch_req.valid = 1'b1;
    fetch_req.addr  = {addr[`RV_XLEN-1:3], 3'b000};
  endfunction

  assign o_bus_req = req_q;
  assign pc_next   = pc_q + 64'd4;
  assign bus_inst  = pc_q[2] ? i_bus_rdata[63:32] : i_bus_rdata[31:0];

  // decode counts as free in the cycle of the retired pulse
  assign free      = !busy_q || i_retired;
  assign bus_take  = req_q.valid && i_bus_ready && !discard_q && !i_redirect;
  assign give      = !i_redirect && free && (bus_take || hold_valid_q);
  assign give_inst = hold_valid_q ? hold_inst_q : bus_inst;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q         <= `RV_RESET_PC;
      req_q        <= '0;
      hold_valid_q <= 1'b0;
      busy_q       <= 1'b0;
      discard_q    <= 1'b0;
      o_fetched    <= 1'b0;
    end else begin
      o_fetched <= give;
      if (i_retired) begin
        busy_q <= 1'b0;
      end
      if (i_redirect) begin
        pc_q         <= i_redirect_pc;
        hold_valid_q <= 1'b0;
        if (req_q.valid && !i_bus_ready) begin
          discard_q <= 1'b1;
        end else begin
          req_q <= fetch_req(i_redirect_pc);
        end
      end else if (give) begin
        // hand over and prefetch the next word at once
        pc_q         <= pc_next;
        hold_valid_q <= 1'b0;
        busy_q       <= 1'b1;
        req_q        <= fetch_req(pc_next);
      end else if (bus_take) begin
        hold_valid_q <= 1'b1;
        req_q.valid  <= 1'b0;
      end else if (req_q.valid && i_bus_ready) begin
        // stale word dropped, go for the target
        discard_q <= 1'b0;
        req_q     <= fetch_req(pc_q);
      end else if (!req_q.valid && !hold_valid_q && !busy_q) begin
        req_q <= fetch_req(pc_q);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (give) begin
      o_pc   <= pc_q;
      o_inst <= give_inst;
    end
    if (bus_take && !free) begin
      hold_inst_q <= bus_inst;
    end
  end

endmodule

//--- design/bus_arbiter.sv
// memory bus arbiter between the instruction fetch and data ports
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  rv_core_pkg::bus_req_t i_if_req,
  output logic                  o_if_ready,
  input  rv_core_pkg::bus_req_t i_dm_req,
  output logic                  o_dm_ready,
  output rv_core_pkg::bus_req_t o_mem_req,
  input  logic                  i_mem_ready
);

  rv_core_pkg::owner_e owner_q;
  rv_core_pkg::owner_e owner_sel;

  // new owner only from idle, data port first
  always_comb begin
    owner_sel = owner_q;
    if (owner_q == rv_core_pkg::own_idle) begin
      if (i_dm_req.valid) begin
        owner_sel = rv_core_pkg::own_data;
      end else if (i_if_req.valid) begin
        owner_sel = rv_core_pkg::own_fetch;
      end
    end
  end

  always_comb begin
    case (owner_sel)
      rv_core_pkg::own_data:  o_mem_req = i_dm_req;
      rv_core_pkg::own_fetch: o_mem_req = i_if_req;
      default:                o_mem_req = '0;
    endcase
  end

  assign o_dm_ready = i_mem_ready && (owner_sel == rv_core_pkg::own_data);
  assign o_if_ready = i_mem_ready && (owner_sel == rv_core_pkg::own_fetch);

  // grant stays locked until ready ends the transfer
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      owner_q <= rv_core_pkg::own_idle;
    end else if (i_mem_ready) begin
      owner_q <= rv_core_pkg::own_idle;
    end else begin
      owner_q <= owner_sel;
    end
  end

endmodule

//--- design/rv_core_pkg.sv
// operation and state enums, bus request and stage payload structs
`include "rv_core_macros.svh"

package rv_core_pkg;

  typedef enum logic [3:0] {
    op_alu,
    op_alui,
    op_lui,
    op_load,
    op_store,
    op_beq,
    op_bne,
    op_jal,
    op_nop
  } op_kind_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor
  } alu_op_e;

  typedef enum logic [1:0] {
    own_idle,
    own_fetch,
    own_data
  } owner_e;

  typedef enum logic [1:0] {
    mw_idle,
    mw_access,
    mw_write
  } mw_state_e;

  // op set means write
  typedef struct packed {
    logic                valid;
    logic                op;
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]   pc;
    op_kind_e              kind;
    alu_op_e               alu_op;
    logic [`RV_RIDX_W-1:0] rd;
    logic                  rd_wen;
    logic [`RV_XLEN-1:0]   op_a;
    logic [`RV_XLEN-1:0]   op_b;
    logic [`RV_XLEN-1:0]   store_data;
    logic [`RV_XLEN-1:0]   imm;
  } decoded_t;

  // result holds the alu value, link value or data address
  typedef struct packed {
    op_kind_e              kind;
    logic [`RV_RIDX_W-1:0] rd;
    logic                  rd_wen;
    logic [`RV_XLEN-1:0]   result;
    logic [`RV_XLEN-1:0]   store_data;
  } executed_t;

endpackage

//--- design/rv_core_macros.svh
// core widths, reset vector, register count, instruction fields and major opcodes
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

`define RV_XLEN        64
`define RV_ILEN        32
`define RV_RIDX_W      5
`define RV_NREGS       32
`define RV_RESET_PC    64'h0

// instruction field positions
`define RV_OPC         6:0
`define RV_RD          11:7
`define RV_F3          14:12
`define RV_RS1         19:15
`define RV_RS2         24:20
`define RV_F7          31:25

// major opcodes of the supported subset
`define RV_OPC_OP      7'b0110011
`define RV_OPC_IMM     7'b0010011
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_LOAD    7'b0000011
`define RV_OPC_STORE   7'b0100011
`define RV_OPC_BRANCH  7'b1100011
`define RV_OPC_JAL     7'b1101111

`endif
